//--- flist.f
design/stream_pkg.sv
design/fifo_ctrl_pkg.sv
design/sync_chain.sv
design/fifo_reset_sync.sv
design/frame_mem.sv
design/frame_write_ctrl.sv
design/frame_read_ctrl.sv
design/status_sync.sv
design/async_frame_fifo.sv
verification/tb_async_frame_fifo.sv

//--- Bender.yml
package:
  name: async_frame_fifo

sources:
  - files:
      - design/stream_pkg.sv
      - design/fifo_ctrl_pkg.sv
      - design/sync_chain.sv
      - design/fifo_reset_sync.sv
      - design/frame_mem.sv
      - design/frame_write_ctrl.sv
      - design/frame_read_ctrl.sv
      - design/status_sync.sv
      - design/async_frame_fifo.sv
  - target: simulation
    files:
      - verification/tb_async_frame_fifo.sv

//--- verification/tb_async_frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_async_frame_fifo
    import stream_pkg::*;
();

    localparam int depth           = 16;
    localparam int pipeline_output = 2;
    localparam int n_frames        = 60;
    localparam int beat_w          = data_width + 2;
    localparam int cls_good        = 0;
    localparam int cls_bad         = 1;
    localparam int cls_over        = 2;

    logic                  async_rst;
    logic                  s_clk;
    logic                  m_clk;
    logic [data_width-1:0] s_data;
    logic                  s_last;
    logic                  s_user;
    logic                  s_valid;
    logic                  s_ready;
    logic [data_width-1:0] m_data;
    logic                  m_last;
    logic                  m_user;
    logic                  m_valid;
    logic                  m_ready;
    logic                  s_status_overflow;
    logic                  s_status_bad_frame;
    logic                  s_status_good_frame;
    logic                  m_status_overflow;
    logic                  m_status_bad_frame;
    logic                  m_status_good_frame;

    // expected beats packed as {data, last, user}
    logic [beat_w-1:0] exp_q [$];
    logic [beat_w-1:0] held_beat;
    int                frame_len [n_frames];
    bit                frame_bad [n_frames];
    int                hold_len [3];
    bit                hold_ready;
    bit                checking;
    bit                stall_q;
    int                beats_accepted;
    int                cycle_count;
    int                cycle_limit;
    int                exp_good;
    int                exp_bad;
    int                exp_over;
    int                s_good_cnt;
    int                s_bad_cnt;
    int                s_over_cnt;
    int                m_good_cnt;
    int                m_bad_cnt;
    int                m_over_cnt;
    int                err_data;
    int                err_flow;
    int                err_status;

    async_frame_fifo #(
        .depth           (depth),
        .pipeline_output (pipeline_output)
    ) i_dut (
        .async_rst           (async_rst),
        .s_clk               (s_clk),
        .m_clk               (m_clk),
        .s_data              (s_data),
        .s_last              (s_last),
        .s_user              (s_user),
        .s_valid             (s_valid),
        .s_ready             (s_ready),
        .m_data              (m_data),
        .m_last              (m_last),
        .m_user              (m_user),
        .m_valid             (m_valid),
        .m_ready             (m_ready),
        .s_status_overflow   (s_status_overflow),
        .s_status_bad_frame  (s_status_bad_frame),
        .s_status_good_frame (s_status_good_frame),
        .m_status_overflow   (m_status_overflow),
        .m_status_bad_frame  (m_status_bad_frame),
        .m_status_good_frame (m_status_good_frame)
    );

    initial begin
        m_clk = 1'b0;
        forever #4 m_clk = ~m_clk;
    end

    // 11 ns so the two clocks slide past each other
    initial begin
        s_clk = 1'b0;
        forever #5.5 s_clk = ~s_clk;
    end

    // what the FIFO must do with a frame of this shape
    function automatic int classify_frame(input int len, input bit user_last);
        if (len > depth) begin
            return cls_over;
        end else if (user_last) begin
            return cls_bad;
        end
        return cls_good;
    endfunction

    task automatic send_frame(input int len, input bit user_last);
        logic [beat_w-1:0] beats [$];
        logic [beat_w-1:0] b;
        int                cls;
        cls = classify_frame(len, user_last);
        for (int i = 0; i < len; i++) begin
            b[beat_w-1:2] = data_width'($urandom);
            b[1] = (i == len - 1);
            b[0] = (i == len - 1) ? user_last : (($urandom % 8) == 0);
            beats.push_back(b);
        end
        if (cls == cls_good) begin
            exp_good++;
            foreach (beats[i]) begin
                exp_q.push_back(beats[i]);
            end
        end else if (cls == cls_bad) begin
            exp_bad++;
        end else begin
            exp_over++;
        end
        for (int i = 0; i < len; i++) begin
            @(negedge s_clk);
            s_valid = 1'b1;
            {s_data, s_last, s_user} = beats[i];
            @(posedge s_clk);
            while (!s_ready) begin
                // past depth beats the frame is being thrown away
                if (i >= depth) begin
                    $display("error at %0t: source stalled inside an oversized frame", $time);
                    err_flow++;
                end
                @(posedge s_clk);
            end
            beats_accepted++;
        end
    endtask

    task automatic idle_source(input int n);
        @(negedge s_clk);
        s_valid = 1'b0;
        repeat (n - 1) @(negedge s_clk);
    endtask

    initial begin
        forever begin
            @(negedge m_clk);
            if (hold_ready) begin
                m_ready = 1'b0;
            end else begin
                m_ready = ($urandom % 10) < 7;
            end
        end
    end

    always @(posedge m_clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("run timed out after %0d m_clk cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(posedge s_clk) begin
        if (checking) begin
            s_good_cnt += s_status_good_frame;
            s_bad_cnt  += s_status_bad_frame;
            s_over_cnt += s_status_overflow;
        end
    end

    always @(posedge m_clk) begin
        if (checking) begin
            m_good_cnt += m_status_good_frame;
            m_bad_cnt  += m_status_bad_frame;
            m_over_cnt += m_status_overflow;
        end
    end

    always @(posedge m_clk) begin : compare_output
        logic [beat_w-1:0] exp_beat;
        logic [beat_w-1:0] out_beat;
        out_beat = {m_data, m_last, m_user};
        if (checking) begin
            // a stalled beat must stay put
            if (stall_q) begin
                if (!m_valid) begin
                    $display("error at %0t: m_valid dropped while stalled", $time);
                    err_flow++;
                end else if (out_beat !== held_beat) begin
                    $display("error at %0t: payload changed while stalled", $time);
                    err_data++;
                end
            end
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    $display("error at %0t: beat 0x%0h with no frame expected", $time, out_beat);
                    err_data++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (m_data !== exp_beat[beat_w-1:2]) begin
                        $display("error at %0t: m_data 0x%0h, expected 0x%0h",
                                 $time, m_data, exp_beat[beat_w-1:2]);
                        err_data++;
                    end
                    if (m_last !== exp_beat[1]) begin
                        $display("error at %0t: m_last %b, expected %b", $time, m_last, exp_beat[1]);
                        err_data++;
                    end
                    if (m_user !== exp_beat[0]) begin
                        $display("error at %0t: m_user %b, expected %b", $time, m_user, exp_beat[0]);
                        err_data++;
                    end
                end
            end
            stall_q   = m_valid && !m_ready;
            held_beat = out_beat;
        end
    end

    initial begin
        int total_beats;
        int gap;
        int accepted_base;
        int held_beats;
        void'($urandom(61));
        s_valid    = 1'b0;
        s_data     = '0;
        s_last     = 1'b0;
        s_user     = 1'b0;
        m_ready    = 1'b0;
        hold_ready = 1'b0;
        async_rst  = 1'b0;
        total_beats = 0;
        for (int i = 0; i < n_frames; i++) begin
            frame_len[i] = ($urandom % 24) + 1;
            frame_bad[i] = ($urandom % 5) == 0;
            total_beats += frame_len[i];
        end
        hold_len[0] = ($urandom % 16) + 1;
        hold_len[1] = depth;
        hold_len[2] = ($urandom % 16) + 1;
        total_beats += hold_len[0] + hold_len[1] + hold_len[2];
        cycle_limit = 30 * total_beats + 2000;

        #1 async_rst = 1'b1;
        repeat (10) @(posedge m_clk);
        @(negedge m_clk);
        async_rst = 1'b0;
        checking  = 1'b1;
        if (m_valid !== 1'b0 || s_ready !== 1'b0) begin
            $display("error at %0t: m_valid or s_ready high at reset release", $time);
            err_flow++;
        end
        if ({s_status_overflow, s_status_bad_frame, s_status_good_frame,
             m_status_overflow, m_status_bad_frame, m_status_good_frame} !== 6'b0) begin
            $display("error at %0t: status output high at reset release", $time);
            err_status++;
        end
        while (s_ready !== 1'b1) @(posedge s_clk);

        // mixed traffic under random back-pressure
        for (int i = 0; i < n_frames; i++) begin
            send_frame(frame_len[i], frame_bad[i]);
            gap = $urandom % 3;
            if (gap != 0) begin
                idle_source(gap);
            end
        end
        idle_source(1);

        // fill with the sink stalled, then drain
        while (exp_q.size() != 0) @(posedge m_clk);
        repeat (20) @(posedge m_clk);
        hold_ready = 1'b1;
        repeat (2) @(posedge m_clk);
        accepted_base = beats_accepted;
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    send_frame(hold_len[i], 1'b0);
                end
                idle_source(1);
            end
            begin
                repeat (300) @(posedge s_clk);
                held_beats = beats_accepted - accepted_base;
                // the output pipeline holds a few beats of its own
                if (held_beats > depth + pipeline_output) begin
                    $display("error at %0t: source took %0d beats with the sink stalled",
                             $time, held_beats);
                    err_flow++;
                end
                if (s_ready) begin
                    $display("error at %0t: s_ready still high with the sink stalled", $time);
                    err_flow++;
                end
                hold_ready = 1'b0;
            end
        join

        while (exp_q.size() != 0) @(posedge m_clk);
        repeat (100) @(posedge m_clk);

        if (s_good_cnt != exp_good || m_good_cnt != exp_good) begin
            $display("error at %0t: good pulses %0d/%0d, expected %0d",
                     $time, s_good_cnt, m_good_cnt, exp_good);
            err_status++;
        end
        if (s_bad_cnt != exp_bad || m_bad_cnt != exp_bad) begin
            $display("error at %0t: bad pulses %0d/%0d, expected %0d",
                     $time, s_bad_cnt, m_bad_cnt, exp_bad);
            err_status++;
        end
        if (s_over_cnt != exp_over || m_over_cnt != exp_over) begin
            $display("error at %0t: overflow pulses %0d/%0d, expected %0d",
                     $time, s_over_cnt, m_over_cnt, exp_over);
            err_status++;
        end

        $display("error counts: data %0d, flow %0d, status %0d", err_data, err_flow, err_status);
        if (err_data + err_flow + err_status == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/async_frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_frame_fifo
    import stream_pkg::*;
    import fifo_ctrl_pkg::*;
#(
    parameter int depth           = 16,
    parameter int pipeline_output = 2
) (
    input  wire                   async_rst,
    input  wire                   s_clk,
    input  wire                   m_clk,
    input  wire  [data_width-1:0] s_data,
    input  wire                   s_last,
    input  wire                   s_user,
    input  wire                   s_valid,
    output logic                  s_ready,
    output logic [data_width-1:0] m_data,
    output logic                  m_last,
    output logic                  m_user,
    output logic                  m_valid,
    input  wire                   m_ready,
    output logic                  s_status_overflow,
    output logic                  s_status_bad_frame,
    output logic                  s_status_good_frame,
    output logic                  m_status_overflow,
    output logic                  m_status_bad_frame,
    output logic                  m_status_good_frame
);

    localparam int addr_width = $clog2(depth);
    localparam int ptr_width  = addr_width + 1;

    logic                  s_rst;
    logic                  m_rst;
    logic                  mem_wr_en;
    logic                  mem_rd_en;
    logic [addr_width-1:0] mem_wr_addr;
    logic [addr_width-1:0] mem_rd_addr;
    beat_t                 mem_wr_beat;
    beat_t                 mem_rd_beat;
    logic [ptr_width-1:0]  rd_gray;
    logic [ptr_width-1:0]  rd_gray_sync;
    logic [ptr_width-1:0]  wr_gray_snap;
    logic [ptr_width-1:0]  wr_gray_snap_sync;
    logic                  upd_req;
    logic                  upd_toggle_sync;
    logic                  upd_ack;
    status_t               s_status;
    status_t               m_status;

    fifo_reset_sync i_reset_sync (
        .async_rst (async_rst),
        .s_clk     (s_clk),
        .m_clk     (m_clk),
        .s_rst     (s_rst),
        .m_rst     (m_rst)
    );

    frame_write_ctrl #(
        .addr_width (addr_width)
    ) i_write_ctrl (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .s_data       (s_data),
        .s_last       (s_last),
        .s_user       (s_user),
        .s_valid      (s_valid),
        .rd_gray_sync (rd_gray_sync),
        .upd_ack      (upd_ack),
        .s_ready      (s_ready),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_beat  (mem_wr_beat),
        .wr_gray_snap (wr_gray_snap),
        .upd_req      (upd_req),
        .status       (s_status)
    );

    frame_mem #(
        .addr_width (addr_width)
    ) i_mem (
        .wr_clk  (s_clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_beat (mem_wr_beat),
        .rd_clk  (m_clk),
        .rd_en   (mem_rd_en),
        .rd_addr (mem_rd_addr),
        .rd_beat (mem_rd_beat)
    );

    frame_read_ctrl #(
        .addr_width      (addr_width),
        .pipeline_output (pipeline_output)
    ) i_read_ctrl (
        .m_clk             (m_clk),
        .m_rst             (m_rst),
        .wr_gray_snap_sync (wr_gray_snap_sync),
        .upd_toggle_sync   (upd_toggle_sync),
        .mem_rd_beat       (mem_rd_beat),
        .m_ready           (m_ready),
        .mem_rd_en         (mem_rd_en),
        .mem_rd_addr       (mem_rd_addr),
        .rd_gray           (rd_gray),
        .m_data            (m_data),
        .m_last            (m_last),
        .m_user            (m_user),
        .m_valid           (m_valid)
    );

    // read pointer back to the source side
    sync_chain #(
        .T      (logic [ptr_width-1:0]),
        .stages (2)
    ) i_rd_gray_sync (
        .clk (s_clk),
        .rst (s_rst),
        .d   (rd_gray),
        .q   (rd_gray_sync)
    );

    // request toggle, one stage longer than the snapshot path
    sync_chain #(
        .T      (logic),
        .stages (3)
    ) i_upd_sync (
        .clk (m_clk),
        .rst (m_rst),
        .d   (upd_req),
        .q   (upd_toggle_sync)
    );

    sync_chain #(
        .T      (logic),
        .stages (2)
    ) i_ack_sync (
        .clk (s_clk),
        .rst (s_rst),
        .d   (upd_toggle_sync),
        .q   (upd_ack)
    );

    // snapshot is held still until the ack returns
    sync_chain #(
        .T      (logic [ptr_width-1:0]),
        .stages (2)
    ) i_snap_sync (
        .clk (m_clk),
        .rst (m_rst),
        .d   (wr_gray_snap),
        .q   (wr_gray_snap_sync)
    );

    status_sync i_status_sync (
        .s_clk    (s_clk),
        .s_rst    (s_rst),
        .m_clk    (m_clk),
        .m_rst    (m_rst),
        .s_status (s_status),
        .m_status (m_status)
    );

    assign s_status_overflow   = s_status.overflow;
    assign s_status_bad_frame  = s_status.bad_frame;
    assign s_status_good_frame = s_status.good_frame;
    assign m_status_overflow   = m_status.overflow;
    assign m_status_bad_frame  = m_status.bad_frame;
    assign m_status_good_frame = m_status.good_frame;

endmodule

`default_nettype wire

//--- design/status_sync.sv
`timescale 1ns/1ps
`default_nettype none

module status_sync
    import fifo_ctrl_pkg::*;
(
    input  wire          s_clk,
    input  wire          s_rst,
    input  wire          m_clk,
    input  wire          m_rst,
    input  wire status_t s_status,
    output status_t      m_status
);

    status_t s_toggle;
    status_t m_toggle_sync;
    status_t m_toggle_q;

    // each source pulse flips its bit
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            s_toggle <= '0;
        end else begin
            s_toggle <= s_toggle ^ s_status;
        end
    end

    sync_chain #(
        .T      (status_t),
        .stages (3)
    ) i_toggle_sync (
        .clk (m_clk),
        .rst (m_rst),
        .d   (s_toggle),
        .q   (m_toggle_sync)
    );

    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            m_toggle_q <= '0;
        end else begin
            m_toggle_q <= m_toggle_sync;
        end
    end

    // one sink cycle per toggle change
    assign m_status = m_toggle_sync ^ m_toggle_q;

endmodule

`default_nettype wire

//--- design/frame_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_read_ctrl
    import stream_pkg::*;
    import fifo_ctrl_pkg::*;
#(
    parameter int addr_width      = 4,
    parameter int pipeline_output = 2
) (
    input  wire                   m_clk,
    input  wire                   m_rst,
    input  wire  [addr_width:0]   wr_gray_snap_sync,
    input  wire                   upd_toggle_sync,
    input  wire  beat_t           mem_rd_beat,
    input  wire                   m_ready,
    output logic                  mem_rd_en,
    output logic [addr_width-1:0] mem_rd_addr,
    output logic [addr_width:0]   rd_gray,
    output logic [data_width-1:0] m_data,
    output logic                  m_last,
    output logic                  m_user,
    output logic                  m_valid
);

    localparam int ptr_width = addr_width + 1;

    logic [ptr_width-1:0]       rd_ptr;
    logic [ptr_width-1:0]       rd_ptr_next;
    logic [ptr_width-1:0]       wr_gray_cap;
    logic                       upd_toggle_q;
    logic                       empty;
    logic [pipeline_output-1:0] valid_q;
    // stage j may move when the output drains or a later stage is empty
    logic [pipeline_output-1:0] adv;
    beat_t                      beat_q [pipeline_output];

    // pick up the committed pointer on each toggle edge
    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            upd_toggle_q <= 1'b0;
            wr_gray_cap  <= '0;
        end else begin
            upd_toggle_q <= upd_toggle_sync;
            if (upd_toggle_sync != upd_toggle_q) begin
                wr_gray_cap <= wr_gray_snap_sync;
            end
        end
    end

    assign empty       = rd_gray == wr_gray_cap;
    assign rd_ptr_next = rd_ptr + 1'b1;
    assign mem_rd_en   = adv[0];
    assign mem_rd_addr = rd_ptr[addr_width-1:0];

    for (genvar j = 0; j < pipeline_output; j++) begin : g_adv
        assign adv[j] = m_ready || !(&valid_q[pipeline_output-1:j]);
    end

    // stage 0 lives in the memory read register
    assign beat_q[0] = mem_rd_beat;

    for (genvar j = 1; j < pipeline_output; j++) begin : g_stage
        always_ff @(posedge m_clk) begin
            if (adv[j]) begin
                beat_q[j] <= beat_q[j-1];
            end
        end
    end

    always_ff @(posedge m_clk or posedge m_rst) begin
        if (m_rst) begin
            rd_ptr  <= '0;
            rd_gray <= '0;
            valid_q <= '0;
        end else begin
            for (int j = pipeline_output - 1; j > 0; j--) begin
                if (adv[j]) begin
                    valid_q[j] <= valid_q[j-1];
                end
            end
            if (adv[0]) begin
                valid_q[0] <= !empty;
                if (!empty) begin
                    rd_ptr  <= rd_ptr_next;
                    rd_gray <= ptr_width'(to_gray(ptr_max_width'(rd_ptr_next)));
                end
            end
        end
    end

    assign m_valid = valid_q[pipeline_output-1];
    assign m_data  = beat_q[pipeline_output-1].data;
    assign m_last  = beat_q[pipeline_output-1].last;
    assign m_user  = beat_q[pipeline_output-1].user;

    a_hold_on_stall: assert property (@(posedge m_clk) disable iff (m_rst)
        m_valid && !m_ready |=> m_valid && $stable({m_data, m_last, m_user}));

    a_no_valid_in_reset: assert property (@(posedge m_clk) m_rst |-> !m_valid);

endmodule

`default_nettype wire

//--- design/frame_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_write_ctrl
    import stream_pkg::*;
    import fifo_ctrl_pkg::*;
#(
    parameter int addr_width = 4
) (
    input  wire                   s_clk,
    input  wire                   s_rst,
    input  wire  [data_width-1:0] s_data,
    input  wire                   s_last,
    input  wire                   s_user,
    input  wire                   s_valid,
    input  wire  [addr_width:0]   rd_gray_sync,
    input  wire                   upd_ack,
    output logic                  s_ready,
    output logic                  mem_wr_en,
    output logic [addr_width-1:0] mem_wr_addr,
    output beat_t                 mem_wr_beat,
    output logic [addr_width:0]   wr_gray_snap,
    output logic                  upd_req,
    output status_t               status
);

    localparam int ptr_width = addr_width + 1;

    // committed pointer and the one that runs ahead inside a frame
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] wr_ptr_cur;
    logic [ptr_width-1:0] cur_next;
    logic [ptr_width-1:0] cur_gray;
    logic [ptr_width-1:0] commit_gray;
    logic [ptr_width-1:0] next_gray;
    logic                 full_cur;
    logic                 full_wr;
    logic                 drop_frame;
    logic                 dropping;
    logic                 accept;
    logic                 accept_en;
    logic                 upd_pending;

    assign cur_next    = wr_ptr_cur + 1'b1;
    assign cur_gray    = ptr_width'(to_gray(ptr_max_width'(wr_ptr_cur)));
    assign commit_gray = ptr_width'(to_gray(ptr_max_width'(wr_ptr)));
    assign next_gray   = ptr_width'(to_gray(ptr_max_width'(cur_next)));

    // top two gray bits differ from the read side, rest equal
    assign full_cur = cur_gray == (rd_gray_sync ^ {2'b11, {(addr_width-1){1'b0}}});
    // frame has already used every slot
    assign full_wr  = wr_ptr == (wr_ptr_cur ^ {1'b1, {addr_width{1'b0}}});

    // an oversized frame keeps flowing so it can be thrown away
    assign s_ready  = (!full_cur || full_wr) && accept_en;
    assign accept   = s_valid && s_ready;
    assign dropping = full_cur || full_wr || drop_frame;

    assign mem_wr_en   = accept && !dropping;
    assign mem_wr_addr = wr_ptr_cur[addr_width-1:0];
    assign mem_wr_beat = '{data: s_data, last: s_last, user: s_user};

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr       <= '0;
            wr_ptr_cur   <= '0;
            wr_gray_snap <= '0;
            upd_req      <= 1'b0;
            upd_pending  <= 1'b0;
            drop_frame   <= 1'b0;
            accept_en    <= 1'b0;
            status       <= '0;
        end else begin
            accept_en <= 1'b1;
            status    <= '0;

            // queued update goes out once the last one is acknowledged
            if (upd_pending && (upd_req == upd_ack)) begin
                upd_pending  <= 1'b0;
                wr_gray_snap <= commit_gray;
                upd_req      <= !upd_ack;
            end

            if (accept) begin
                if (dropping) begin
                    drop_frame <= 1'b1;
                    if (s_last) begin
                        // discard the whole frame
                        wr_ptr_cur      <= wr_ptr;
                        drop_frame      <= 1'b0;
                        status.overflow <= 1'b1;
                    end
                end else begin
                    wr_ptr_cur <= cur_next;
                    if (s_last && s_user) begin
                        wr_ptr_cur       <= wr_ptr;
                        status.bad_frame <= 1'b1;
                    end else if (s_last) begin
                        wr_ptr            <= cur_next;
                        status.good_frame <= 1'b1;
                        if (upd_req == upd_ack) begin
                            upd_pending  <= 1'b0;
                            wr_gray_snap <= next_gray;
                            upd_req      <= !upd_ack;
                        end else begin
                            // crossing busy, send when the ack comes back
                            upd_pending <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    a_no_ready_in_reset: assert property (@(posedge s_clk) s_rst |-> !s_ready);

endmodule

`default_nettype wire

//--- design/frame_mem.sv
`timescale 1ns/1ps
`default_nettype none

module frame_mem
    import stream_pkg::*;
#(
    parameter int addr_width = 4
) (
    input  wire                   wr_clk,
    input  wire                   wr_en,
    input  wire  [addr_width-1:0] wr_addr,
    input  wire  beat_t           wr_beat,
    input  wire                   rd_clk,
    input  wire                   rd_en,
    input  wire  [addr_width-1:0] rd_addr,
    output beat_t                 rd_beat
);

    beat_t mem [2**addr_width];

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // read register doubles as the first output stage
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- design/fifo_reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_reset_sync (
    input  wire  async_rst,
    input  wire  s_clk,
    input  wire  m_clk,
    output logic s_rst,
    output logic m_rst
);

    (* shreg_extract = "no" *)
    logic [2:0] s_rst_q;
    (* shreg_extract = "no" *)
    logic [2:0] m_rst_q;

    // stage 1 of both chains feeds stage 2 of each, so neither side runs alone
    always_ff @(posedge s_clk or posedge async_rst) begin
        if (async_rst) begin
            s_rst_q <= '1;
        end else begin
            s_rst_q <= {s_rst_q[1], s_rst_q[0] | m_rst_q[0], 1'b0};
        end
    end

    always_ff @(posedge m_clk or posedge async_rst) begin
        if (async_rst) begin
            m_rst_q <= '1;
        end else begin
            m_rst_q <= {m_rst_q[1], s_rst_q[0] | m_rst_q[0], 1'b0};
        end
    end

    assign s_rst = s_rst_q[2];
    assign m_rst = m_rst_q[2];

endmodule

`default_nettype wire

//--- design/sync_chain.sv
`timescale 1ns/1ps
`default_nettype none

module sync_chain #(
    parameter type T      = logic,
    parameter int  stages = 2
) (
    input  wire   clk,
    input  wire   rst,
    input  wire T d,
    output T      q
);

    // keep as discrete flops near each other
    (* shreg_extract = "no" *)
    T sync_q [stages];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < stages; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= d;
            for (int i = 1; i < stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign q = sync_q[stages-1];

endmodule

`default_nettype wire

//--- design/fifo_ctrl_pkg.sv
`default_nettype none

package fifo_ctrl_pkg;

    // widest pointer the gray helper takes
    localparam int ptr_max_width = 16;

    // one-cycle event flags, same layout on both sides
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } status_t;

    // callers size the argument up and cut the result back
    function automatic logic [ptr_max_width-1:0] to_gray(
        input logic [ptr_max_width-1:0] bin
    );
        return bin ^ (bin >> 1);
    endfunction

endpackage

`default_nettype wire

//--- design/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // byte-wide stream payload
    localparam int data_width = 8;

    // one beat as it sits in the frame memory
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
        // marks a bad frame when set on the last beat
        logic                  user;
    } beat_t;

endpackage

`default_nettype wire
